// ==== compile.f ====
verilog/acq_pkg.sv
verilog/frame_pkg.sv
verilog/acq_config.sv
verilog/acq_sequencer.sv
verilog/frame_writer.sv
verilog/sample_fifo.sv
verilog/credit_merger.sv
verilog/acq_top.sv
tests/acq_tb.sv

// ==== tests/acq_tb.sv ====
`timescale 1ns/1ps

module acq_tb import acq_pkg::*, frame_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_ENTRIES    = 5;
    localparam int WAIT_LIMIT   = 4000;
    localparam int WATCHDOG_NS  =
        N_ENTRIES * (CHECK_CYCLES + CONF_CYCLES + 300) * CLK_PERIOD +
        N_ENTRIES * RESET_CYCLES * CLK_PERIOD;

    // The columns are delayed credits, dev_kind, intan_id and the expected
    // ch0 and ch1 lengths.
    localparam logic [0:N_ENTRIES-1][50:0] STIM = {
        {1'b0, 2'd0, 32'h1234_5678, 8'd0,  8'd0},
        {1'b0, 2'd1, 32'hFFF0_0010, 8'd0,  8'd32},
        {1'b0, 2'd2, 32'hA5A5_0F0F, 8'd0,  8'd64},
        {1'b0, 2'd3, 32'hFFC8_7FF0, 8'd64, 8'd64},
        {1'b1, 2'd3, 32'h0042_FFE0, 8'd64, 8'd64}
    };

    logic              clk;
    logic              rst;
    logic [KIND_W-1:0] dev_kind;
    logic [31:0]       intan_id;
    logic              fs_check;
    logic              fs_conf;
    logic              fs_read;
    logic              credit_return;
    logic [KIND_W-1:0] dev_type;
    logic              fd_check;
    logic              fd_conf;
    logic              fd_read;
    logic              out_valid;
    logic [WORD_W-1:0] out_data;

    int                errors       = 0;
    int                seed         = 64;
    int                received     = 0;
    int                returned     = 0;
    int                owed         = 0;
    int                gap_left     = 0;
    int                wr_count     = 0;
    logic              delayed_mode = 1'b0;
    logic              ret_next     = 1'b0;
    logic [WORD_W-1:0] got[$];
    logic [WORD_W-1:0] exp_words[$];

    acq_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .dev_kind      (dev_kind),
        .intan_id      (intan_id),
        .fs_check      (fs_check),
        .fs_conf       (fs_conf),
        .fs_read       (fs_read),
        .credit_return (credit_return),
        .dev_type      (dev_type),
        .fd_check      (fd_check),
        .fd_conf       (fd_conf),
        .fd_read       (fd_read),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("errors: %0d", errors);
        $display("tests failed");
        $finish;
    end

    // ******************************************************************
    // Output monitor and credit-returning consumer
    // ******************************************************************

    // Bookkeeping happens on the falling edge. The credit level follows on
    // the next rising edge, and a credit counts as returned once the DUT
    // sees it.
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            got.push_back(out_data);
            received++;
            owed++;
        end
        if (credit_return === 1'b1) begin
            returned++;
        end
        if (i_dut.wr_en_ch0 === 1'b1) begin
            wr_count++;
        end
        if (i_dut.wr_en_ch1 === 1'b1) begin
            wr_count++;
        end
        if (received - returned > CREDIT_MAX) begin
            errors++;
            $display("credit limit exceeded, %0d words outstanding", received - returned);
        end
        if (owed > 0 && gap_left == 0) begin
            ret_next = 1'b1;
            owed--;
            if (owed == 0 && delayed_mode) begin
                gap_left = $random(seed) & 7;
            end
        end else begin
            ret_next = 1'b0;
            if (gap_left > 0) begin
                gap_left--;
            end
        end
    end

    always @(posedge clk) begin
        credit_return <= ret_next;
    end

    // ******************************************************************
    // Helpers
    // ******************************************************************

    task automatic report_mismatch(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
        errors++;
        $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    endtask

    function automatic string phase_name(input int ph);
        case (ph)
            0:       return "fd_check";
            1:       return "fd_conf";
            default: return "fd_read";
        endcase
    endfunction

    function automatic logic done_level(input int ph);
        case (ph)
            0:       return fd_check;
            1:       return fd_conf;
            default: return fd_read;
        endcase
    endfunction

    task automatic set_start(input int ph, input logic level);
        case (ph)
            0:       fs_check <= level;
            1:       fs_conf <= level;
            default: fs_read <= level;
        endcase
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        if (fd_check !== 1'b0) report_mismatch("fd_check", fd_check, 0);
        if (fd_conf !== 1'b0) report_mismatch("fd_conf", fd_conf, 0);
        if (fd_read !== 1'b0) report_mismatch("fd_read", fd_read, 0);
        if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
        if (dev_type !== '0) report_mismatch("dev_type", dev_type, 0);
        @(posedge clk);
        rst <= 1'b0;
    endtask

    // Latency counts from the first edge that sees the start level high.
    task automatic measure_phase(input int ph, output int lat);
        int   cycles;
        logic found;
        @(posedge clk);
        set_start(ph, 1'b1);
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            found = done_level(ph);
        end
        if (!found) begin
            errors++;
            $display("%s never rose after its start level was raised", phase_name(ph));
            lat = -1;
        end else begin
            lat = cycles - 1;
        end
    endtask

    task automatic release_phase(input int ph);
        @(posedge clk);
        set_start(ph, 1'b0);
        @(posedge clk);
        @(negedge clk);
        if (done_level(ph)) begin
            errors++;
            $display("%s did not fall after its start level was dropped", phase_name(ph));
        end
    endtask

    // Reference frames put channel 0 first, each a header followed by the id
    // part plus the sample index.
    task automatic build_expected(input logic [50:0] e);
        logic [7:0]  len0;
        logic [7:0]  len1;
        logic [15:0] id0;
        logic [15:0] id1;
        int          i;
        exp_words.delete();
        len0 = e[15:8];
        len1 = e[7:0];
        id0  = e[31:16];
        id1  = e[47:32];
        if (len0 != 0) begin
            exp_words.push_back({HDR_TAG, 1'b0, 11'(len0)});
            for (i = 0; i < len0; i++) begin
                exp_words.push_back(id0 + 16'(i));
            end
        end
        if (len1 != 0) begin
            exp_words.push_back({HDR_TAG, 1'b1, 11'(len1)});
            for (i = 0; i < len1; i++) begin
                exp_words.push_back(id1 + 16'(i));
            end
        end
    endtask

    task automatic run_read();
        int lat;
        int t;
        int i;
        @(posedge clk);
        got.delete();
        wr_count = 0;
        measure_phase(2, lat);
        @(posedge clk);
        fs_read <= 1'b0;
        if (wr_count != exp_words.size()) begin
            report_mismatch("words written before fd_read", wr_count, exp_words.size());
        end
        @(posedge clk);
        @(negedge clk);
        if (fd_read) begin
            errors++;
            $display("fd_read did not fall after fs_read was dropped");
        end
        t = 0;
        while (got.size() < exp_words.size() && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        if (got.size() < exp_words.size()) begin
            errors++;
            $display("output words missing after waiting %0d cycles", t);
        end
        // A few idle cycles show up any word beyond the frames.
        repeat (6) @(posedge clk);
        if (got.size() != exp_words.size()) begin
            report_mismatch("out_valid word count", got.size(), exp_words.size());
        end
        for (i = 0; i < got.size() && i < exp_words.size(); i++) begin
            if (got[i] !== exp_words[i]) begin
                report_mismatch($sformatf("out_data word %0d", i), got[i], exp_words[i]);
            end
        end
        t = 0;
        while (owed != 0 && t < WAIT_LIMIT) begin
            @(posedge clk);
            t++;
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic run_entry(input int n);
        logic [50:0] e;
        int          lat;
        e = STIM[n];
        @(posedge clk);
        dev_kind     <= e[49:48];
        intan_id     <= e[47:16];
        delayed_mode <= e[50];
        apply_reset();
        repeat (3) @(posedge clk);
        measure_phase(0, lat);
        if (lat != CHECK_CYCLES + 3) report_mismatch("fd_check latency", lat, CHECK_CYCLES + 3);
        if (dev_type !== e[49:48]) report_mismatch("dev_type", dev_type, e[49:48]);
        release_phase(0);
        measure_phase(1, lat);
        if (lat != CONF_CYCLES + 3) report_mismatch("fd_conf latency", lat, CONF_CYCLES + 3);
        release_phase(1);
        build_expected(e);
        run_read();
        run_read();
    endtask

    // ******************************************************************
    // Main sequence
    // ******************************************************************

    initial begin
        rst           = 1'b1;
        dev_kind      = '0;
        intan_id      = '0;
        fs_check      = 1'b0;
        fs_conf       = 1'b0;
        fs_read       = 1'b0;
        credit_return = 1'b0;
        for (int n = 0; n < N_ENTRIES; n++) begin
            run_entry(n);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog/acq_top.sv ====
`timescale 1ns/1ps

module acq_top import acq_pkg::*, frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [KIND_W-1:0] dev_kind,
    input  logic [31:0]       intan_id,
    input  logic              fs_check,
    input  logic              fs_conf,
    input  logic              fs_read,
    input  logic              credit_return,
    output logic [KIND_W-1:0] dev_type,
    output logic              fd_check,
    output logic              fd_conf,
    output logic              fd_read,
    output logic              out_valid,
    output logic [WORD_W-1:0] out_data
);

    logic              latch_kind;
    logic              clear_kind;
    logic              frame_start;
    logic [LEN_W-1:0]  len_ch0;
    logic [LEN_W-1:0]  len_ch1;
    logic              done_ch0;
    logic              done_ch1;
    logic              wr_en_ch0;
    logic              wr_en_ch1;
    logic [WORD_W-1:0] wr_data_ch0;
    logic [WORD_W-1:0] wr_data_ch1;
    logic              full_ch0;
    logic              full_ch1;
    logic              empty_ch0;
    logic              empty_ch1;
    logic              rd_en_ch0;
    logic              rd_en_ch1;
    logic [WORD_W-1:0] rd_data_ch0;
    logic [WORD_W-1:0] rd_data_ch1;

    acq_config u_config (
        .clk        (clk),
        .rst        (rst),
        .dev_kind   (dev_kind),
        .latch_kind (latch_kind),
        .clear_kind (clear_kind),
        .dev_type   (dev_type),
        .len_ch0    (len_ch0),
        .len_ch1    (len_ch1)
    );

    acq_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .fs_check    (fs_check),
        .fs_conf     (fs_conf),
        .fs_read     (fs_read),
        .done_ch0    (done_ch0),
        .done_ch1    (done_ch1),
        .fd_check    (fd_check),
        .fd_conf     (fd_conf),
        .fd_read     (fd_read),
        .frame_start (frame_start),
        .latch_kind  (latch_kind),
        .clear_kind  (clear_kind)
    );

    // Channel 0 takes the low half of the chip id, channel 1 the high half.
    frame_writer u_writer_ch0 (
        .clk         (clk),
        .rst         (rst),
        .channel     (1'b0),
        .frame_start (frame_start),
        .frame_len   (len_ch0),
        .id_part     (intan_id[15:0]),
        .fifo_full   (full_ch0),
        .wr_en       (wr_en_ch0),
        .wr_data     (wr_data_ch0),
        .frame_done  (done_ch0)
    );

    frame_writer u_writer_ch1 (
        .clk         (clk),
        .rst         (rst),
        .channel     (1'b1),
        .frame_start (frame_start),
        .frame_len   (len_ch1),
        .id_part     (intan_id[31:16]),
        .fifo_full   (full_ch1),
        .wr_en       (wr_en_ch1),
        .wr_data     (wr_data_ch1),
        .frame_done  (done_ch1)
    );

    sample_fifo u_fifo_ch0 (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en_ch0),
        .wr_data (wr_data_ch0),
        .rd_en   (rd_en_ch0),
        .rd_data (rd_data_ch0),
        .full    (full_ch0),
        .empty   (empty_ch0)
    );

    sample_fifo u_fifo_ch1 (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en_ch1),
        .wr_data (wr_data_ch1),
        .rd_en   (rd_en_ch1),
        .rd_data (rd_data_ch1),
        .full    (full_ch1),
        .empty   (empty_ch1)
    );

    credit_merger u_merger (
        .clk           (clk),
        .rst           (rst),
        .empty_ch0     (empty_ch0),
        .empty_ch1     (empty_ch1),
        .data_ch0      (rd_data_ch0),
        .data_ch1      (rd_data_ch1),
        .credit_return (credit_return),
        .rd_en_ch0     (rd_en_ch0),
        .rd_en_ch1     (rd_en_ch1),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

// ==== verilog/credit_merger.sv ====
`timescale 1ns/1ps

module credit_merger import frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              empty_ch0,
    input  logic              empty_ch1,
    input  logic [WORD_W-1:0] data_ch0,
    input  logic [WORD_W-1:0] data_ch1,
    input  logic              credit_return,
    output logic              rd_en_ch0,
    output logic              rd_en_ch1,
    output logic              out_valid,
    output logic [WORD_W-1:0] out_data
);

    logic [CREDIT_W-1:0]  credit;
    logic [CREDIT_W-1:0]  committed;
    logic                 credit_ok;
    logic                 locked;
    logic                 sel;
    logic                 hdr_wait;
    logic                 inflight;
    logic [HDR_LEN_W-1:0] remaining;
    frame_word_u          cur_word;

    // Words already read but not yet paid for still hold a credit.
    assign committed = CREDIT_W'(out_valid) + CREDIT_W'(inflight);
    assign credit_ok = (credit > committed);
    assign cur_word  = sel ? data_ch1 : data_ch0;

    // **********************************************************************
    // Read selection
    // **********************************************************************

    always_comb begin
        rd_en_ch0 = 1'b0;
        rd_en_ch1 = 1'b0;
        if (credit_ok) begin
            if (!locked) begin
                // Channel 0 wins when both hold a frame.
                if (!empty_ch0) begin
                    rd_en_ch0 = 1'b1;
                end else if (!empty_ch1) begin
                    rd_en_ch1 = 1'b1;
                end
            end else if (!hdr_wait) begin
                rd_en_ch0 = !sel && !empty_ch0;
                rd_en_ch1 = sel && !empty_ch1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked    <= 1'b0;
            sel       <= 1'b0;
            hdr_wait  <= 1'b0;
            remaining <= '0;
        end else if (!locked) begin
            if (rd_en_ch0 || rd_en_ch1) begin
                locked   <= 1'b1;
                sel      <= rd_en_ch1;
                hdr_wait <= 1'b1;
            end
        end else if (hdr_wait) begin
            // The header is on the FIFO output now.
            hdr_wait  <= 1'b0;
            remaining <= cur_word.hdr.len;
            if (cur_word.hdr.len == '0) begin
                locked <= 1'b0;
            end
        end else if (rd_en_ch0 || rd_en_ch1) begin
            remaining <= remaining - 1'b1;
            if (remaining == HDR_LEN_W'(1)) begin
                locked <= 1'b0;
            end
        end
    end

    // **********************************************************************
    // Output register and credits
    // **********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inflight  <= 1'b0;
            out_valid <= 1'b0;
            credit    <= CREDIT_W'(CREDIT_MAX);
        end else begin
            inflight  <= rd_en_ch0 || rd_en_ch1;
            out_valid <= inflight;
            credit    <= credit - CREDIT_W'(out_valid) + CREDIT_W'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (inflight) begin
            out_data <= cur_word.sample;
        end
    end

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo import frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  logic [WORD_W-1:0] wr_data,
    input  logic              rd_en,
    output logic [WORD_W-1:0] rd_data,
    output logic              full,
    output logic              empty
);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW:0]  wr_ptr;
    logic [FIFO_AW:0]  rd_ptr;
    logic              do_wr;
    logic              do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // The extra pointer bit tells a full FIFO from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr[FIFO_AW-1:0]];
        end
    end

endmodule

// ==== verilog/frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer import acq_pkg::*, frame_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              channel,
    input  logic              frame_start,
    input  logic [LEN_W-1:0]  frame_len,
    input  logic [WORD_W-1:0] id_part,
    input  logic              fifo_full,
    output logic              wr_en,
    output logic [WORD_W-1:0] wr_data,
    output logic              frame_done
);

    logic             busy;
    logic             hdr_phase;
    logic [LEN_W-1:0] idx;
    frame_word_u      word;

    // A word goes out in every busy cycle in which the FIFO has room.
    assign wr_en = busy && !fifo_full;

    always_comb begin
        word = '0;
        if (hdr_phase) begin
            word.hdr.tag  = HDR_TAG;
            word.hdr.chan = channel;
            word.hdr.len  = frame_len[HDR_LEN_W-1:0];
        end else begin
            word.sample = id_part + WORD_W'(idx);
        end
    end

    assign wr_data = word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            hdr_phase  <= 1'b0;
            idx        <= '0;
            frame_done <= 1'b0;
        end else if (!frame_start) begin
            frame_done <= 1'b0;
        end else if (!busy && !frame_done) begin
            // An empty channel finishes at once and writes nothing.
            if (frame_len == '0) begin
                frame_done <= 1'b1;
            end else begin
                busy      <= 1'b1;
                hdr_phase <= 1'b1;
                idx       <= '0;
            end
        end else if (wr_en) begin
            if (hdr_phase) begin
                hdr_phase <= 1'b0;
            end else if (idx == frame_len - 1'b1) begin
                busy       <= 1'b0;
                frame_done <= 1'b1;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/acq_sequencer.sv ====
`timescale 1ns/1ps

module acq_sequencer import acq_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic fs_check,
    input  logic fs_conf,
    input  logic fs_read,
    input  logic done_ch0,
    input  logic done_ch1,
    output logic fd_check,
    output logic fd_conf,
    output logic fd_read,
    output logic frame_start,
    output logic latch_kind,
    output logic clear_kind
);

    seq_state_t        state;
    seq_state_t        next_state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              frames_done;

    assign frames_done = done_ch0 && done_ch1;

    // **********************************************************************
    // Phase state machine
    // **********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:        next_state = ST_CHECK_WAIT;
            ST_CHECK_WAIT:  if (fs_check) next_state = ST_CHECK_BEGIN;
            ST_CHECK_BEGIN: next_state = ST_CHECK_COUNT;
            ST_CHECK_COUNT: begin
                if (wait_cnt == WAIT_W'(CHECK_CYCLES)) begin
                    next_state = ST_CHECK_LAST;
                end
            end
            ST_CHECK_LAST:  next_state = ST_CHECK_DONE;
            ST_CHECK_DONE:  if (!fs_check) next_state = ST_CONF_WAIT;
            ST_CONF_WAIT:   if (fs_conf) next_state = ST_CONF_BEGIN;
            ST_CONF_BEGIN:  next_state = ST_CONF_COUNT;
            ST_CONF_COUNT: begin
                if (wait_cnt == WAIT_W'(CONF_CYCLES)) begin
                    next_state = ST_CONF_LAST;
                end
            end
            ST_CONF_LAST:   next_state = ST_CONF_DONE;
            ST_CONF_DONE:   if (!fs_conf) next_state = ST_READ_WAIT;
            ST_READ_WAIT:   if (fs_read) next_state = ST_READ_START;
            ST_READ_START:  if (frames_done) next_state = ST_READ_DONE;
            ST_READ_DONE:   if (!fs_read) next_state = ST_READ_WAIT;
            default:        next_state = ST_IDLE;
        endcase
    end

    // **********************************************************************
    // Wait counter
    // **********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (state == ST_CHECK_BEGIN || state == ST_CONF_BEGIN ||
                     state == ST_CHECK_LAST || state == ST_CONF_LAST) begin
            wait_cnt <= '0;
        end else if (state == ST_CHECK_COUNT || state == ST_CONF_COUNT) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign fd_check    = (state == ST_CHECK_DONE);
    assign fd_conf     = (state == ST_CONF_DONE);
    assign fd_read     = (state == ST_READ_DONE);
    assign frame_start = (state == ST_READ_START);
    assign latch_kind  = (state == ST_CHECK_LAST);
    assign clear_kind  = (state == ST_IDLE);

endmodule

// ==== verilog/acq_config.sv ====
`timescale 1ns/1ps

module acq_config import acq_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [KIND_W-1:0] dev_kind,
    input  logic              latch_kind,
    input  logic              clear_kind,
    output logic [KIND_W-1:0] dev_type,
    output logic [LEN_W-1:0]  len_ch0,
    output logic [LEN_W-1:0]  len_ch1
);

    // The kind is captured at the end of the chip check and held until the
    // sequencer passes through idle again.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_type <= '0;
        end else if (latch_kind) begin
            dev_type <= dev_kind;
        end else if (clear_kind) begin
            dev_type <= '0;
        end
    end

    // Lengths follow the latched kind, so they stay fixed during a read.
    assign len_ch0 = FRAME_LEN_CH0[dev_type];
    assign len_ch1 = FRAME_LEN_CH1[dev_type];

endmodule

// ==== verilog/frame_pkg.sv ====
package frame_pkg;

    localparam int WORD_W    = 16;
    localparam int HDR_LEN_W = 11;

    localparam logic [3:0] HDR_TAG = 4'hA;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    localparam int CREDIT_MAX = 8;
    localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

    // One frame word. The first word of a frame is a header and every
    // following word is a plain sample.
    typedef union packed {
        struct packed {
            logic [3:0]           tag;
            logic                 chan;
            logic [HDR_LEN_W-1:0] len;
        } hdr;
        logic [WORD_W-1:0] sample;
    } frame_word_u;

endpackage

// ==== verilog/acq_pkg.sv ====
package acq_pkg;

    // Sequencer state encoding. The check and configuration phases share the
    // same shape: wait, begin, count, last, done.
    typedef enum logic [7:0] {
        ST_IDLE        = 8'h11,
        ST_CHECK_WAIT  = 8'h21,
        ST_CHECK_BEGIN = 8'hA0,
        ST_CHECK_COUNT = 8'hA2,
        ST_CHECK_LAST  = 8'hA1,
        ST_CHECK_DONE  = 8'h12,
        ST_CONF_WAIT   = 8'h41,
        ST_CONF_BEGIN  = 8'hB0,
        ST_CONF_COUNT  = 8'hB2,
        ST_CONF_LAST   = 8'hB1,
        ST_CONF_DONE   = 8'h22,
        ST_READ_WAIT   = 8'h81,
        ST_READ_START  = 8'h82,
        ST_READ_DONE   = 8'h84
    } seq_state_t;

    localparam int WAIT_W       = 16;
    localparam int CHECK_CYCLES = 100;
    localparam int CONF_CYCLES  = 400;

    localparam int KIND_W = 2;
    localparam int LEN_W  = 12;

    // Samples per read for each device kind. Index 0 is the leftmost entry.
    localparam logic [0:(1<<KIND_W)-1][LEN_W-1:0] FRAME_LEN_CH0 =
        {12'd0, 12'd0, 12'd0, 12'd64};
    localparam logic [0:(1<<KIND_W)-1][LEN_W-1:0] FRAME_LEN_CH1 =
        {12'd0, 12'd32, 12'd64, 12'd64};

endpackage
